/* verilog.f */
enemyPkg.sv
frameTick.sv
enemyWalkAnim.sv
enemy.sv
spriteMux.sv
enemyRegs.sv
enemyField.sv
enemyField_sva.sv
tbEnemyField.sv

/* Makefile */
TOP := tbEnemyField

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module enemyField -f verilog.f
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* tbEnemyField.sv */
`default_nettype none

module tbEnemyField;
    timeunit 1ns;
    timeprecision 100ps;
    import enemyPkg::*;

    typedef struct packed {
        logic [8:0] playerX;
        logic [8:0] playerY;
        logic [3:0] aliveMask;
        logic [9:0] strobes;
        logic       probe;      // Query pixels after the row
    } stimRow_t;

    localparam int NUM_ROWS = 8;

    logic                 Clk      = 1'b0;
    logic                 arstN    = 1'b0;
    logic                 frameClk = 1'b0;
    apbReq_t              apbReq   = '0;
    apbRsp_t              apbRsp;
    pos_t                 pixel    = '0;
    logic                 isObj;
    logic [ID_W-1:0]      objId;
    logic [SPRITE_AW-1:0] spriteAddr;

    stimRow_t stim [NUM_ROWS];
    integer   seed;
    int       cycles       = 0;
    int       timeoutLimit = 0;
    int       riseCount    = 0;   // Frame rises since reset

    // Reference model of the enemy states
    int mX    [NUM_ENEMIES];
    int mY    [NUM_ENEMIES];
    int mDir  [NUM_ENEMIES];
    int mStep [NUM_ENEMIES];

    always #10 Clk = ~Clk;

    enemyField u_dut (
        .Clk        (Clk),
        .arstN      (arstN),
        .frameClk   (frameClk),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .pixel      (pixel),
        .isObj      (isObj),
        .objId      (objId),
        .spriteAddr (spriteAddr)
    );

    bind enemyField enemyField_sva u_sva (
        .Clk      (Clk),
        .arstN    (arstN),
        .apbRsp   (apbRsp),
        .moveTick (moveTick),
        .states   (states),
        .alive    (alive)
    );

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles > timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("RESULT: FAIL");
            $fatal(1, "stopped by timeout");
        end
    end

    task automatic compareValue(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            $display("ERR %s exp=%h got=%h", name, expVal, gotVal);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic apbTransfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, input logic expErr,
                               output logic [31:0] rdata);
        int waits;
        @(posedge Clk);
        apbReq.psel    <= 1'b1;   // Setup phase
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= write;
        apbReq.paddr   <= addr;
        apbReq.pwdata  <= wdata;
        @(posedge Clk);
        apbReq.penable <= 1'b1;
        @(negedge Clk);
        waits = 0;
        while (apbRsp.pready !== 1'b1) begin
            if (waits == 16) begin
                $display("APB transfer at address %h never got pready", addr);
                $display("RESULT: FAIL");
                $fatal(1, "APB handshake stuck");
            end
            waits++;
            @(negedge Clk);
        end
        compareValue($sformatf("pslverr@%h", addr), 32'(expErr), 32'(apbRsp.pslverr));
        rdata = apbRsp.prdata;
        @(posedge Clk);              // Access phase ends here
        apbReq.psel    <= 1'b0;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                            input logic expErr);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, expErr, unused);
    endtask

    task automatic apbRead(input logic [11:0] addr, input logic expErr,
                           output logic [31:0] data);
        apbTransfer(1'b0, addr, 32'd0, expErr, data);
    endtask

    task automatic checkControlRegs(input logic [31:0] playerWord, input logic [3:0] mask);
        logic [31:0] word;
        apbRead(REG_PLAYER, 1'b0, word);
        compareValue("REG_PLAYER", playerWord, word);
        apbRead(REG_ALIVE, 1'b0, word);
        compareValue("REG_ALIVE", {28'd0, mask}, word);
    endtask

    task automatic checkEnemies();
        logic [31:0] word;
        logic [31:0] expWord;
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            apbRead(REG_ENEMY_BASE + 12'(4 * i), 1'b0, word);
            expWord = 32'(mX[i]) | (32'(mY[i]) << 16)
                    | (32'(mDir[i]) << 28) | (32'(mStep[i]) << 30);
            compareValue($sformatf("enemy%0d state", i), expWord, word);
        end
    endtask

    // One movement tick of the chase rule, X first, then Y
    task automatic modelTick(input int px, input int py, input logic [3:0] mask);
        int stepSize;
        int nx;
        int ny;
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            if (mask[i]) begin
                stepSize = 1 + (i % 2);
                nx = mX[i];
                ny = mY[i];
                if (mX[i] < px) begin
                    mDir[i] = 3;
                    if (mX[i] + int'(SPRITE_W) < int'(X_MAX)) begin
                        nx = mX[i] + stepSize;
                    end
                end else if (mX[i] > px) begin
                    mDir[i] = 1;
                    if (mX[i] > int'(X_MIN)) begin
                        nx = (mX[i] - stepSize < int'(X_MIN)) ? int'(X_MIN) : mX[i] - stepSize;
                    end
                end else if (mY[i] < py) begin
                    mDir[i] = 0;
                    if (mY[i] + int'(SPRITE_H) < int'(Y_MAX)) begin
                        ny = mY[i] + stepSize;
                    end
                end else if (mY[i] > py) begin
                    mDir[i] = 2;
                    if (mY[i] > int'(Y_MIN)) begin
                        ny = (mY[i] - stepSize < int'(Y_MIN)) ? int'(Y_MIN) : mY[i] - stepSize;
                    end
                end
                if (nx != mX[i] || ny != mY[i]) begin
                    mStep[i] = (mStep[i] + 1) % 4;
                end
                mX[i] = nx;
                mY[i] = ny;
            end
        end
    endtask

    // High for 3 cycles, low for 3
    task automatic sendStrobe(input int px, input int py, input logic [3:0] mask);
        @(posedge Clk);
        frameClk <= 1'b1;
        repeat (3) @(posedge Clk);
        frameClk <= 1'b0;
        repeat (2) @(posedge Clk);
        riseCount++;
        if (riseCount % TICK_DIV == 0) begin
            modelTick(px, py, mask);
        end
    endtask

    task automatic probePixel(input int px, input int py, input logic [3:0] mask);
        logic expHit;
        int   expId;
        int   expAddr;
        int   frame;
        expHit  = 1'b0;
        expId   = 0;
        expAddr = 0;
        @(posedge Clk);
        pixel <= '{x: 9'(px), y: 9'(py)};
        @(negedge Clk);
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            if (!expHit && mask[i] && px >= mX[i] && px < mX[i] + 26
                    && py >= mY[i] && py < mY[i] + 26) begin
                expHit = 1'b1;   // Lowest ID found first
                expId  = i;
                frame  = (mStep[i] % 2 == 0) ? 3 * mDir[i] : 3 * mDir[i] + 1 + mStep[i] / 2;
                expAddr = (px - mX[i]) + (py - mY[i]) * 26 + 676 * frame;
            end
        end
        compareValue($sformatf("isObj(%0d,%0d)", px, py), 32'(expHit), 32'(isObj));
        compareValue($sformatf("objId(%0d,%0d)", px, py), 32'(expId), 32'(objId));
        compareValue($sformatf("spriteAddr(%0d,%0d)", px, py), 32'(expAddr),
                     32'(spriteAddr));
    endtask

    initial begin
        int          totalStrobes;
        logic [31:0] playerWord;
        seed = 32'h5faf;

        // Columns: player x, player y, alive mask, frame strobes, probe flag
        stim[0] = '{9'd150, 9'd120, 4'b1111, 10'd16,  1'b1};
        stim[1] = '{9'd150, 9'd120, 4'b0101, 10'd12,  1'b1};
        stim[2] = '{9'd400, 9'd300, 4'b1111, 10'd64,  1'b0};
        stim[3] = '{9'd400, 9'd300, 4'b1010, 10'd40,  1'b1};   // Enemy 3 hits the right edge
        stim[4] = '{9'd187, 9'd0,   4'b1111, 10'd80,  1'b1};   // Enemy 1 climbs to the status bar
        stim[5] = '{9'd187, 9'd240, 4'b0110, 10'd240, 1'b1};   // Enemies 1 and 2 overlap
        stim[6] = '{9'd187, 9'd240, 4'b0110, 10'd64,  1'b1};   // Both stop at the bottom limit
        stim[7] = '{9'd0,   9'd0,   4'b1001, 10'd514, 1'b1};   // Leaves rises pending

        totalStrobes = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            totalStrobes += int'(stim[r].strobes);
        end
        timeoutLimit = totalStrobes * 6 + 2000;

        for (int i = 0; i < NUM_ENEMIES; i++) begin
            mX[i]    = 70 * (i + 1) - 13;   // Centre minus half a sprite
            mY[i]    = 40 * (i + 1) - 13;
            mDir[i]  = 0;
            mStep[i] = 0;
        end

        repeat (5) @(posedge Clk);
        arstN <= 1'b1;
        checkEnemies();
        checkControlRegs(32'd0, 4'd0);

        // Register access rules
        playerWord = {7'd0, 9'd100, 7'd0, 9'd200};
        apbWrite(REG_PLAYER, playerWord, 1'b0);
        apbWrite(REG_ALIVE, 32'h5, 1'b0);
        checkControlRegs(playerWord, 4'h5);
        apbWrite(REG_ENEMY_BASE + 12'h4, 32'hffff_ffff, 1'b1);
        apbWrite(12'h008, 32'h0000_0003, 1'b1);
        apbWrite(12'h020, 32'h0000_000f, 1'b1);
        apbRead(12'h008, 1'b1, playerWord);
        apbRead(12'h012, 1'b1, playerWord);   // Misaligned enemy word
        playerWord = {7'd0, 9'd100, 7'd0, 9'd200};
        checkControlRegs(playerWord, 4'h5);
        checkEnemies();

        for (int r = 0; r < NUM_ROWS; r++) begin
            playerWord = {7'd0, stim[r].playerY, 7'd0, stim[r].playerX};
            apbWrite(REG_PLAYER, playerWord, 1'b0);
            apbWrite(REG_ALIVE, {28'd0, stim[r].aliveMask}, 1'b0);
            checkControlRegs(playerWord, stim[r].aliveMask);
            for (int s = 0; s < int'(stim[r].strobes); s++) begin
                sendStrobe(int'(stim[r].playerX), int'(stim[r].playerY), stim[r].aliveMask);
            end
            repeat (4) @(posedge Clk);
            checkEnemies();
            if (stim[r].probe) begin
                for (int i = 0; i < NUM_ENEMIES; i++) begin
                    probePixel(mX[i] + int'({$random(seed)} % 26),
                               mY[i] + int'({$random(seed)} % 26), stim[r].aliveMask);
                end
                probePixel(int'({$random(seed)} % 320), int'({$random(seed)} % 240),
                           stim[r].aliveMask);
                probePixel(319, 239, stim[r].aliveMask);   // Below every enemy
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* enemyField_sva.sv */
`default_nettype none

module enemyField_sva (
    input wire                               Clk,
    input wire                               arstN,
    input wire enemyPkg::apbRsp_t            apbRsp,
    input wire                               moveTick,
    input wire enemyPkg::enemyState_t        states [enemyPkg::NUM_ENEMIES],
    input wire [enemyPkg::NUM_ENEMIES-1:0]   alive
);
    timeunit 1ns;
    timeprecision 100ps;
    import enemyPkg::*;

    // Slave has no wait states
    readyHigh: assert property (@(posedge Clk) disable iff (!arstN) apbRsp.pready)
        else $error("pready went low");

    tickSingle: assert property (@(posedge Clk) disable iff (!arstN) moveTick |=> !moveTick)
        else $error("moveTick lasted two cycles");

    for (genvar i = 0; i < NUM_ENEMIES; i++) begin : genDeadHold
        deadHold: assert property (@(posedge Clk) disable iff (!arstN)
            !alive[i] |=> $stable(states[i]))
            else $error("enemy %0d changed state while dead", i);
    end

endmodule

`default_nettype wire

/* enemyField.sv */
`default_nettype none

module enemyField (
    input  wire                              Clk,
    input  wire                              arstN,
    input  wire                              frameClk,
    input  wire  enemyPkg::apbReq_t          apbReq,
    output enemyPkg::apbRsp_t                apbRsp,
    input  wire  enemyPkg::pos_t             pixel,
    output logic                             isObj,
    output logic [enemyPkg::ID_W-1:0]        objId,
    output logic [enemyPkg::SPRITE_AW-1:0]   spriteAddr
);
    import enemyPkg::*;

    logic                   moveTick;
    pos_t                   player;
    logic [NUM_ENEMIES-1:0] alive;
    enemyState_t            states [NUM_ENEMIES];
    logic [NUM_ENEMIES-1:0] hits;
    logic [SPRITE_AW-1:0]   addrs [NUM_ENEMIES];

    frameTick u_frameTick (
        .Clk      (Clk),
        .arstN    (arstN),
        .frameClk (frameClk),
        .moveTick (moveTick)
    );

    enemyRegs u_regs (
        .Clk    (Clk),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .states (states),
        .player (player),
        .alive  (alive)
    );

    for (genvar i = 0; i < NUM_ENEMIES; i++) begin : genEnemy
        enemy #(
            .id (i)
        ) u_enemy (
            .Clk      (Clk),
            .arstN    (arstN),
            .moveTick (moveTick),
            .alive    (alive[i]),
            .player   (player),
            .pixel    (pixel),     // Same query pixel for all
            .state    (states[i]),
            .hit      (hits[i]),
            .addr     (addrs[i])
        );
    end

    spriteMux u_mux (
        .hits       (hits),
        .addrs      (addrs),
        .isObj      (isObj),
        .objId      (objId),
        .spriteAddr (spriteAddr)
    );

endmodule

`default_nettype wire

/* enemyRegs.sv */
`default_nettype none

module enemyRegs (
    input  wire                             Clk,
    input  wire                             arstN,
    input  wire  enemyPkg::apbReq_t         apbReq,
    output enemyPkg::apbRsp_t               apbRsp,
    input  wire  enemyPkg::enemyState_t     states [enemyPkg::NUM_ENEMIES],
    output enemyPkg::pos_t                  player,
    output logic [enemyPkg::NUM_ENEMIES-1:0] alive
);
    import enemyPkg::*;

    logic            access;      // APB access phase
    logic            selPlayer;
    logic            selAlive;
    logic            selEnemy;
    logic            addrErr;
    logic [ID_W-1:0] enemyIdx;
    logic [31:0]     readWord;

    assign access    = apbReq.psel && apbReq.penable;
    assign selPlayer = (apbReq.paddr == REG_PLAYER);
    assign selAlive  = (apbReq.paddr == REG_ALIVE);
    assign selEnemy  = (apbReq.paddr >= REG_ENEMY_BASE)
                    && (apbReq.paddr <= REG_ENEMY_LAST)
                    && (apbReq.paddr[1:0] == 2'b00);   // Word aligned only
    assign enemyIdx  = ID_W'((apbReq.paddr - REG_ENEMY_BASE) >> 2);

    // Unmapped, or a write to a read-only enemy word
    assign addrErr = !(selPlayer || selAlive || selEnemy)
                  || (apbReq.pwrite && selEnemy);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            player <= '0;
            alive  <= '0;
        end else if (access && apbReq.pwrite && !addrErr) begin
            if (selPlayer) begin
                player.x <= apbReq.pwdata[8:0];
                player.y <= apbReq.pwdata[24:16];
            end
            if (selAlive) begin
                alive <= apbReq.pwdata[NUM_ENEMIES-1:0];
            end
        end
    end

    // Read word layout follows the register map
    always_comb begin
        readWord = '0;
        if (selPlayer) begin
            readWord[8:0]   = player.x;
            readWord[24:16] = player.y;
        end else if (selAlive) begin
            readWord[NUM_ENEMIES-1:0] = alive;
        end else if (selEnemy) begin
            readWord[8:0]   = states[enemyIdx].x;
            readWord[24:16] = states[enemyIdx].y;
            readWord[29:28] = states[enemyIdx].dir;
            readWord[31:30] = states[enemyIdx].step;
        end
    end

    // No wait states
    assign apbRsp = '{
        prdata:  (access && !apbReq.pwrite) ? readWord : 32'd0,
        pready:  1'b1,
        pslverr: access && addrErr
    };

endmodule

`default_nettype wire

/* spriteMux.sv */
`default_nettype none

module spriteMux (
    input  wire  [enemyPkg::NUM_ENEMIES-1:0] hits,
    input  wire  [enemyPkg::SPRITE_AW-1:0]   addrs [enemyPkg::NUM_ENEMIES],
    output logic                             isObj,
    output logic [enemyPkg::ID_W-1:0]        objId,
    output logic [enemyPkg::SPRITE_AW-1:0]   spriteAddr
);
    import enemyPkg::*;

    // Lowest ID is drawn on top, so scan downwards and let it win last
    always_comb begin
        isObj      = 1'b0;
        objId      = '0;
        spriteAddr = '0;
        for (int i = NUM_ENEMIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                isObj      = 1'b1;
                objId      = ID_W'(i);
                spriteAddr = addrs[i];
            end
        end
    end

endmodule

`default_nettype wire

/* enemy.sv */
`default_nettype none

module enemy #(
    parameter int id = 0
) (
    input  wire                             Clk,
    input  wire                             arstN,
    input  wire                             moveTick,
    input  wire                             alive,
    input  wire  enemyPkg::pos_t            player,
    input  wire  enemyPkg::pos_t            pixel,
    output enemyPkg::enemyState_t           state,
    output logic                            hit,
    output logic [enemyPkg::SPRITE_AW-1:0]  addr
);
    import enemyPkg::*;

    // Spawn point, centre of the sprite at (70, 40) times (id + 1)
    localparam logic [8:0] startX   = 9'(70 * (id + 1)) - (SPRITE_W >> 1);
    localparam logic [8:0] startY   = 9'(40 * (id + 1)) - (SPRITE_H >> 1);
    localparam logic [8:0] stepSize = 9'(1 + id % 2);   // Odd IDs run twice as fast

    logic [8:0] posX;
    logic [8:0] posY;
    dir_e       dir;
    logic [1:0] step;

    logic [8:0] nextX;
    logic [8:0] nextY;
    dir_e       nextDir;
    logic       moving;

    logic [8:0] dx;   // Pixel offset inside the sprite
    logic [8:0] dy;
    logic [3:0] frame;

    // Chase rule, X is settled before Y
    always_comb begin
        nextX   = posX;
        nextY   = posY;
        nextDir = dir;
        if (alive) begin
            if (posX < player.x) begin
                nextDir = DIR_RIGHT;
                if (posX + SPRITE_W < X_MAX) begin
                    nextX = posX + stepSize;
                end
            end else if (posX > player.x) begin
                nextDir = DIR_LEFT;
                if (posX > X_MIN) begin
                    // Land on the limit instead of wrapping below it
                    nextX = (posX - X_MIN < stepSize) ? X_MIN : posX - stepSize;
                end
            end else if (posY < player.y) begin
                nextDir = DIR_DOWN;
                if (posY + SPRITE_H < Y_MAX) begin
                    nextY = posY + stepSize;
                end
            end else if (posY > player.y) begin
                nextDir = DIR_UP;
                if (posY > Y_MIN) begin
                    nextY = (posY - Y_MIN < stepSize) ? Y_MIN : posY - stepSize;
                end
            end
        end
    end

    assign moving = (nextX != posX) || (nextY != posY);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            posX <= startX;
            posY <= startY;
            dir  <= DIR_DOWN;
        end else if (moveTick) begin
            posX <= nextX;   // Dead enemies see next == current
            posY <= nextY;
            dir  <= nextDir;
        end
    end

    enemyWalkAnim u_walkAnim (
        .Clk      (Clk),
        .arstN    (arstN),
        .moveTick (moveTick),
        .moving   (moving),
        .step     (step)
    );

    assign state = '{x: posX, y: posY, dir: dir, step: step};

    // Pixel coverage
    assign dx  = pixel.x - posX;
    assign dy  = pixel.y - posY;
    assign hit = alive
              && (pixel.x >= posX) && (pixel.x < posX + SPRITE_W)
              && (pixel.y >= posY) && (pixel.y < posY + SPRITE_H);

    // Three frames per direction: standing, stride A, stride B
    always_comb begin
        if (step[0]) begin
            frame = 4'(dir) * 4'd3 + 4'd1 + 4'(step[1]);
        end else begin
            frame = 4'(dir) * 4'd3;
        end
    end

    always_comb begin
        if (hit) begin
            addr = SPRITE_AW'(dx)
                 + SPRITE_AW'(dy) * SPRITE_AW'(SPRITE_W)
                 + FRAME_WORDS * SPRITE_AW'(frame);
        end else begin
            addr = '0;
        end
    end

endmodule

`default_nettype wire

/* enemyWalkAnim.sv */
`default_nettype none

// Walk cycle of one enemy
//   step 0 and 2 show the standing frame,
//   step 1 and 3 show the two stride frames (picked by bit 1)
module enemyWalkAnim (
    input  wire        Clk,
    input  wire        arstN,
    input  wire        moveTick,
    input  wire        moving,     // Next motion of this enemy is non-zero
    output logic [1:0] step
);

    logic advance;

    // Blocked or idle enemies keep their current pose
    assign advance = moveTick && moving;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            step <= 2'd0;
        end else if (advance) begin
            step <= step + 2'd1;   // Wraps after the second stride
        end
    end

endmodule

`default_nettype wire

/* frameTick.sv */
`default_nettype none

module frameTick (
    input  wire  Clk,
    input  wire  arstN,
    input  wire  frameClk,
    output logic moveTick
);
    import enemyPkg::*;

    logic                  frameSync1;   // frameClk is asynchronous to Clk
    logic                  frameSync2;
    logic                  frameLast;    // Previous synchronised level
    logic                  frameRise;
    logic [TICK_CNT_W-1:0] riseCnt;

    assign frameRise = frameSync2 & ~frameLast;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            frameSync1 <= 1'b0;
            frameSync2 <= 1'b0;
            frameLast  <= 1'b0;
        end else begin
            frameSync1 <= frameClk;
            frameSync2 <= frameSync1;
            frameLast  <= frameSync2;
        end
    end

    // One tick every TICK_DIV frame rises, the first on rise number TICK_DIV
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            riseCnt  <= '0;
            moveTick <= 1'b0;
        end else if (frameRise && riseCnt == TICK_LAST) begin
            riseCnt  <= '0;
            moveTick <= 1'b1;
        end else if (frameRise) begin
            riseCnt  <= riseCnt + 1'b1;
            moveTick <= 1'b0;
        end else begin
            moveTick <= 1'b0;   // Single-cycle pulse
        end
    end

endmodule

`default_nettype wire

/* enemyPkg.sv */
`default_nettype none

package enemyPkg;

    // Enemy array
    localparam int NUM_ENEMIES = 4;
    localparam int ID_W        = $clog2(NUM_ENEMIES);  // Width of an enemy ID

    // Sprite geometry, one sprite frame is W x H words of ROM
    localparam logic [8:0] SPRITE_W = 9'd26;
    localparam logic [8:0] SPRITE_H = 9'd26;
    localparam int SPRITE_AW = 13;
    localparam logic [SPRITE_AW-1:0] FRAME_WORDS = SPRITE_AW'(32'(SPRITE_W) * 32'(SPRITE_H));

    // Playing field, top-left corner of a sprite stays inside these
    localparam logic [8:0] X_MIN = 9'd0;
    localparam logic [8:0] X_MAX = 9'd319;
    localparam logic [8:0] Y_MIN = 9'd52;   // Area above is the status bar
    localparam logic [8:0] Y_MAX = 9'd205;

    // Movement tick divider
    localparam int TICK_DIV   = 4;           // Frame strobes per movement tick
    localparam int TICK_CNT_W = $clog2(TICK_DIV);
    localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(TICK_DIV - 1);

    // Register map
    localparam logic [11:0] REG_PLAYER     = 12'h000;  // X in 8:0, Y in 24:16
    localparam logic [11:0] REG_ALIVE      = 12'h004;  // Alive mask in 3:0
    localparam logic [11:0] REG_ENEMY_BASE = 12'h010;  // Read-only, one word per enemy
    localparam logic [11:0] REG_ENEMY_LAST = REG_ENEMY_BASE + 12'(4 * (NUM_ENEMIES - 1));

    // Facing direction, doubles as the sprite row group
    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_e;

    // Screen coordinate
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } pos_t;

    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
        dir_e       dir;
        logic [1:0] step;   // Walk animation counter
    } enemyState_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire
